// ==== axi_to_lite.f ====
+incdir+source
source/axi_bridge_pkg.sv
source/axi_burst_splitter.sv
source/axi_xact_fifo.sv
source/axi_read_tracker.sv
source/axi_write_merger.sv
source/axi_to_lite.sv
test/tb_axi_to_lite.sv

// ==== source/axi_bridge_config.svh ====
`ifndef AXI_BRIDGE_CONFIG_SVH
`define AXI_BRIDGE_CONFIG_SVH

// Width of the AXI transaction ID on the master side
`define AXI_ID_WIDTH 4

// Address width shared by the AXI and the AXI-Lite port
`define AXI_ADDR_WIDTH 32

// Data width shared by both ports, strobes are one bit per byte
`define AXI_DATA_WIDTH 32

// Number of bursts that may be in flight per direction
// Two lets a new burst start while the previous one is still answered
`define AXI_XACT_FIFO_DEPTH 2

// Bursts never cross a 4K page, so only these low address bits ever change
`define AXI_PAGE_BITS 12

`endif

// ==== source/axi_bridge_pkg.sv ====
`include "axi_bridge_config.svh"

package axi_bridge_pkg;

    // Number of low address bits that a burst is allowed to step through
    localparam int PAGE_BITS = `AXI_PAGE_BITS;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } burst_t;

    // Bit 1 set means an error response
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_t;

    typedef logic [2:0] prot_t;

    // What the response side needs to know about a burst
    // The len field is the AXI length, so it holds beats minus one
    typedef struct packed {
        logic [`AXI_ID_WIDTH-1:0] id;
        logic [7:0]               len;
    } xact_t;

    // Next beat address within the page for the three burst types
    function automatic logic [PAGE_BITS-1:0] next_page_addr(
        input logic [PAGE_BITS-1:0] addr,
        input logic [2:0]           size,
        input logic [3:0]           wrap_len,
        input burst_t               burst
    );
        logic [PAGE_BITS-1:0] step;
        logic [PAGE_BITS-1:0] incr_mask;
        logic [PAGE_BITS-1:0] wrap_mask;
        logic [PAGE_BITS-1:0] next;
        step      = PAGE_BITS'(1) << size;
        incr_mask = step - 1'b1;
        // Wrap lengths are 1, 3, 7 or 15, so shifted by the size they form the wrap window mask
        wrap_mask = PAGE_BITS'(wrap_len) << size;
        case (burst)
            BURST_FIXED: next = addr;
            BURST_INCR:  next = (addr & ~incr_mask) + step;
            // Only bits inside the window take the carry, the rest of the address stays put
            BURST_WRAP:  next = ((addr + step) & wrap_mask) | (addr & ~wrap_mask);
            default:     next = addr;
        endcase
        return next;
    endfunction

endpackage

// ==== source/axi_burst_splitter.sv ====
`timescale 1ns/1ps
`include "axi_bridge_config.svh"

module axi_burst_splitter (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         in_valid,
    input  logic [`AXI_ADDR_WIDTH-1:0]   in_addr,
    input  logic [7:0]                   in_len,
    input  logic [2:0]                   in_size,
    input  axi_bridge_pkg::burst_t       in_burst,
    input  axi_bridge_pkg::prot_t        in_prot,
    input  logic                         out_ready,
    input  logic                         fifo_room,
    output logic                         in_ready,
    output logic                         out_valid,
    output logic [`AXI_ADDR_WIDTH-1:0]   out_addr,
    output axi_bridge_pkg::prot_t        out_prot,
    output logic                         push
);

    import axi_bridge_pkg::*;

    // High while the remaining beats of a burst are being sent
    logic                       in_burst_q;

    // Burst attributes captured from the first beat
    logic [2:0]                 size_q;
    burst_t                     burst_q;
    prot_t                      prot_q;
    logic [3:0]                 wrap_len_q;

    // Address of the beat last sent and the beats still to go after it
    logic [`AXI_ADDR_WIDTH-1:0] addr_q;
    logic [7:0]                 len_q;

    logic [`AXI_ADDR_WIDTH-1:0] addr_next;
    logic [7:0]                 len_next;

    // The page bits step, everything above them stays the same for the whole burst
    assign addr_next = {addr_q[`AXI_ADDR_WIDTH-1:PAGE_BITS],
                        next_page_addr(addr_q[PAGE_BITS-1:0], size_q, wrap_len_q, burst_q)};
    assign len_next  = len_q - 8'd1;

    // When idle the master beat goes straight through, but only if the FIFO can take its entry
    // In burst mode the splitter owns the Lite channel and the master is held off
    assign out_valid = in_burst_q ? 1'b1 : (in_valid && fifo_room);
    assign in_ready  = in_burst_q ? 1'b0 : (out_ready && fifo_room);
    assign out_addr  = in_burst_q ? addr_next : in_addr;
    assign out_prot  = in_burst_q ? prot_q : in_prot;

    // One FIFO entry per master burst, written on its first beat
    assign push = !in_burst_q && in_valid && in_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            in_burst_q <= 1'b0;
        end else if (in_burst_q) begin
            // Leave burst mode once the final beat is taken by the Lite side
            if (out_ready && len_next == 8'd0) begin
                in_burst_q <= 1'b0;
            end
        end else if (push && in_len != 8'd0) begin
            // Single-beat bursts are done with the pass-through beat
            in_burst_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!in_burst_q) begin
            if (push) begin
                size_q     <= in_size;
                burst_q    <= in_burst;
                prot_q     <= in_prot;
                addr_q     <= in_addr;
                len_q      <= in_len;
                // Wrap lengths fit in four bits
                wrap_len_q <= in_len[3:0];
            end
        end else if (out_ready) begin
            // The beat on the Lite channel was accepted so step to the next one
            addr_q <= addr_next;
            len_q  <= len_next;
        end
    end

endmodule

// ==== source/axi_read_tracker.sv ====
`timescale 1ns/1ps
`include "axi_bridge_config.svh"

module axi_read_tracker (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      lite_valid,
    input  logic                      lite_ready,
    input  axi_bridge_pkg::xact_t     head,
    output logic                      pop,
    output logic [`AXI_ID_WIDTH-1:0]  r_id,
    output logic                      r_last
);

    import axi_bridge_pkg::*;

    // High between the first and the last beat of a multi-beat read
    logic                     in_burst_q;
    logic [`AXI_ID_WIDTH-1:0] id_q;
    // Beats still expected after the one most recently accepted
    logic [7:0]               len_q;

    logic [7:0]               len_next;
    logic                     beat;

    assign beat     = lite_valid && lite_ready;
    assign len_next = len_q - 8'd1;

    // The FIFO entry is consumed with the first beat, later beats use the stored copy
    assign pop    = !in_burst_q && beat;
    assign r_id   = in_burst_q ? id_q : head.id;
    assign r_last = (in_burst_q ? len_next : head.len) == 8'd0;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            in_burst_q <= 1'b0;
        end else if (in_burst_q) begin
            if (beat && len_next == 8'd0) begin
                in_burst_q <= 1'b0;
            end
        end else if (pop && head.len != 8'd0) begin
            // More beats follow this one
            in_burst_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            id_q  <= head.id;
            len_q <= head.len;
        end else if (in_burst_q && beat) begin
            len_q <= len_next;
        end
    end

endmodule

// ==== source/axi_to_lite.sv ====
`timescale 1ns/1ps
`include "axi_bridge_config.svh"

module axi_to_lite (
    input  logic                          clk,
    input  logic                          rstn,

    // AXI slave port facing the master
    input  logic [`AXI_ID_WIDTH-1:0]      s_ar_id,
    input  logic [`AXI_ADDR_WIDTH-1:0]    s_ar_addr,
    input  logic [7:0]                    s_ar_len,
    input  logic [2:0]                    s_ar_size,
    input  axi_bridge_pkg::burst_t        s_ar_burst,
    input  axi_bridge_pkg::prot_t         s_ar_prot,
    input  logic                          s_ar_valid,
    output logic                          s_ar_ready,
    output logic [`AXI_ID_WIDTH-1:0]      s_r_id,
    output logic [`AXI_DATA_WIDTH-1:0]    s_r_data,
    output axi_bridge_pkg::resp_t         s_r_resp,
    output logic                          s_r_last,
    output logic                          s_r_valid,
    input  logic                          s_r_ready,
    input  logic [`AXI_ID_WIDTH-1:0]      s_aw_id,
    input  logic [`AXI_ADDR_WIDTH-1:0]    s_aw_addr,
    input  logic [7:0]                    s_aw_len,
    input  logic [2:0]                    s_aw_size,
    input  axi_bridge_pkg::burst_t        s_aw_burst,
    input  axi_bridge_pkg::prot_t         s_aw_prot,
    input  logic                          s_aw_valid,
    output logic                          s_aw_ready,
    input  logic [`AXI_DATA_WIDTH-1:0]    s_w_data,
    input  logic [`AXI_DATA_WIDTH/8-1:0]  s_w_strb,
    // Bursts cannot be interleaved, so the beat count from the aw side is enough and last goes unused
    input  logic                          s_w_last,
    input  logic                          s_w_valid,
    output logic                          s_w_ready,
    output logic [`AXI_ID_WIDTH-1:0]      s_b_id,
    output axi_bridge_pkg::resp_t         s_b_resp,
    output logic                          s_b_valid,
    input  logic                          s_b_ready,

    // AXI-Lite master port facing the slave
    output logic [`AXI_ADDR_WIDTH-1:0]    m_ar_addr,
    output axi_bridge_pkg::prot_t         m_ar_prot,
    output logic                          m_ar_valid,
    input  logic                          m_ar_ready,
    input  logic [`AXI_DATA_WIDTH-1:0]    m_r_data,
    input  axi_bridge_pkg::resp_t         m_r_resp,
    input  logic                          m_r_valid,
    output logic                          m_r_ready,
    output logic [`AXI_ADDR_WIDTH-1:0]    m_aw_addr,
    output axi_bridge_pkg::prot_t         m_aw_prot,
    output logic                          m_aw_valid,
    input  logic                          m_aw_ready,
    output logic [`AXI_DATA_WIDTH-1:0]    m_w_data,
    output logic [`AXI_DATA_WIDTH/8-1:0]  m_w_strb,
    output logic                          m_w_valid,
    input  logic                          m_w_ready,
    input  axi_bridge_pkg::resp_t         m_b_resp,
    input  logic                          m_b_valid,
    output logic                          m_b_ready
);

    import axi_bridge_pkg::*;

    // Burst ID and length travel from each address channel to its response channel
    xact_t ar_xact;
    xact_t aw_xact;
    xact_t rd_head;
    xact_t wr_head;

    logic  ar_push;
    logic  aw_push;
    logic  rd_room;
    logic  wr_room;
    logic  rd_pop;
    logic  wr_pop;

    assign ar_xact = '{id: s_ar_id, len: s_ar_len};
    assign aw_xact = '{id: s_aw_id, len: s_aw_len};

    axi_burst_splitter u_ar_split (
        .clk       (clk),        .rstn      (rstn),
        .in_valid  (s_ar_valid), .in_addr   (s_ar_addr),  .in_len   (s_ar_len),
        .in_size   (s_ar_size),  .in_burst  (s_ar_burst), .in_prot  (s_ar_prot),
        .out_ready (m_ar_ready), .fifo_room (rd_room),    .in_ready (s_ar_ready),
        .out_valid (m_ar_valid), .out_addr  (m_ar_addr),  .out_prot (m_ar_prot),
        .push      (ar_push)
    );

    // The write address side stalls on the write FIFO only
    axi_burst_splitter u_aw_split (
        .clk       (clk),        .rstn      (rstn),
        .in_valid  (s_aw_valid), .in_addr   (s_aw_addr),  .in_len   (s_aw_len),
        .in_size   (s_aw_size),  .in_burst  (s_aw_burst), .in_prot  (s_aw_prot),
        .out_ready (m_aw_ready), .fifo_room (wr_room),    .in_ready (s_aw_ready),
        .out_valid (m_aw_valid), .out_addr  (m_aw_addr),  .out_prot (m_aw_prot),
        .push      (aw_push)
    );

    axi_xact_fifo u_rd_fifo (
        .clk  (clk),     .rstn      (rstn),    .push  (ar_push),
        .push_xact (ar_xact), .pop  (rd_pop),  .room  (rd_room),
        .avail     (),        .head (rd_head)
    );

    axi_xact_fifo u_wr_fifo (
        .clk  (clk),     .rstn      (rstn),    .push  (aw_push),
        .push_xact (aw_xact), .pop  (wr_pop),  .room  (wr_room),
        .avail     (),        .head (wr_head)
    );

    // Read data and response go straight through, with master back-pressure on the Lite ready
    assign s_r_data  = m_r_data;
    assign s_r_resp  = m_r_resp;
    assign s_r_valid = m_r_valid;
    assign m_r_ready = s_r_ready;

    axi_read_tracker u_rd_track (
        .clk        (clk),       .rstn       (rstn),
        .lite_valid (m_r_valid), .lite_ready (m_r_ready), .head (rd_head),
        .pop        (rd_pop),    .r_id       (s_r_id),    .r_last (s_r_last)
    );

    // Write data needs no tracking
    assign m_w_data  = s_w_data;
    assign m_w_strb  = s_w_strb;
    assign m_w_valid = s_w_valid;
    assign s_w_ready = m_w_ready;

    axi_write_merger u_wr_merge (
        .clk          (clk),       .rstn        (rstn),
        .lite_b_valid (m_b_valid), .lite_b_resp (m_b_resp), .b_ready (s_b_ready),
        .head         (wr_head),   .lite_b_ready (m_b_ready), .pop    (wr_pop),
        .b_valid      (s_b_valid), .b_id        (s_b_id),   .b_resp  (s_b_resp)
    );

endmodule

// ==== source/axi_write_merger.sv ====
`timescale 1ns/1ps
`include "axi_bridge_config.svh"

module axi_write_merger (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      lite_b_valid,
    input  axi_bridge_pkg::resp_t     lite_b_resp,
    input  logic                      b_ready,
    input  axi_bridge_pkg::xact_t     head,
    output logic                      lite_b_ready,
    output logic                      pop,
    output logic                      b_valid,
    output logic [`AXI_ID_WIDTH-1:0]  b_id,
    output axi_bridge_pkg::resp_t     b_resp
);

    import axi_bridge_pkg::*;

    // High while the Lite responses of a multi-beat write are being collected
    logic                     in_burst_q;
    logic [`AXI_ID_WIDTH-1:0] id_q;
    // Responses still expected after the one most recently accepted
    logic [7:0]               len_q;
    // Response merged over the beats accepted so far
    resp_t                    resp_q;

    logic [7:0]               len_next;
    resp_t                    resp_next;
    logic                     last;
    logic                     lite_hs;

    assign len_next  = len_q - 8'd1;

    // The first error seen sticks, until then the newest response is taken
    assign resp_next = resp_q[1] ? resp_q : lite_b_resp;

    // True when the Lite response on the bus closes the burst
    assign last = (in_burst_q ? len_next : head.len) == 8'd0;

    // Only the closing response is shown to the master and waits for it
    // Every earlier one is absorbed here without stalling the Lite slave
    assign b_valid      = last && lite_b_valid;
    assign lite_b_ready = last ? b_ready : 1'b1;
    assign b_id         = in_burst_q ? id_q : head.id;
    assign b_resp       = in_burst_q ? resp_next : lite_b_resp;

    assign lite_hs = lite_b_valid && lite_b_ready;
    assign pop     = !in_burst_q && lite_hs;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            in_burst_q <= 1'b0;
        end else if (in_burst_q) begin
            if (lite_hs && len_next == 8'd0) begin
                in_burst_q <= 1'b0;
            end
        end else if (pop && head.len != 8'd0) begin
            in_burst_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            // First response of the burst seeds the merged value
            id_q   <= head.id;
            len_q  <= head.len;
            resp_q <= lite_b_resp;
        end else if (in_burst_q && lite_hs) begin
            len_q  <= len_next;
            resp_q <= resp_next;
        end
    end

endmodule

// ==== source/axi_xact_fifo.sv ====
`timescale 1ns/1ps
`include "axi_bridge_config.svh"

module axi_xact_fifo (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  push,
    input  axi_bridge_pkg::xact_t push_xact,
    input  logic                  pop,
    output logic                  room,
    output logic                  avail,
    output axi_bridge_pkg::xact_t head
);

    import axi_bridge_pkg::*;

    localparam int DEPTH = `AXI_XACT_FIFO_DEPTH;
    // Keep the pointers at least one bit wide even for a single entry
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    xact_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic             do_push;
    logic             do_pop;

    assign room  = count != CNT_W'(DEPTH);
    assign avail = count != '0;
    assign head  = mem[rd_ptr];

    // Requests against a full or empty buffer are dropped
    assign do_push = push && room;
    assign do_pop  = pop && avail;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // A push and a pop in the same cycle leave the fill level unchanged
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_xact;
        end
    end

endmodule

// ==== test/tb_axi_to_lite.sv ====
`timescale 1ns/1ps
`include "axi_bridge_config.svh"

module tb_axi_to_lite;

    import axi_bridge_pkg::*;

    localparam int NUM_ROWS = 10;
    localparam int MAX_BEATS = 64;
    // Reset time plus a fixed budget for every table row
    localparam int TIMEOUT_CYCLES = 10 + 64 * NUM_ROWS;

    // One AXI burst, err_idx is the Lite beat that answers with an error or -1 for none
    typedef struct {
        bit                       is_wr;
        logic [`AXI_ID_WIDTH-1:0] id;
        logic [31:0]              addr;
        int                       len;
        int                       size;
        burst_t                   burst;
        prot_t                    prot;
        int                       err_idx;
    } row_t;

    row_t rows [NUM_ROWS];

    logic clk;
    logic rstn;
    logic [`AXI_ID_WIDTH-1:0] s_ar_id, s_r_id, s_aw_id, s_b_id;
    logic [`AXI_ADDR_WIDTH-1:0] s_ar_addr, s_aw_addr, m_ar_addr, m_aw_addr;
    logic [7:0] s_ar_len, s_aw_len;
    logic [2:0] s_ar_size, s_aw_size;
    burst_t s_ar_burst, s_aw_burst;
    prot_t s_ar_prot, s_aw_prot, m_ar_prot, m_aw_prot;
    logic [`AXI_DATA_WIDTH-1:0] s_r_data, s_w_data, m_r_data, m_w_data;
    logic [`AXI_DATA_WIDTH/8-1:0] s_w_strb, m_w_strb;
    resp_t s_r_resp, s_b_resp, m_r_resp, m_b_resp;
    logic s_ar_valid, s_ar_ready, s_r_last, s_r_valid, s_r_ready, s_aw_valid, s_aw_ready;
    logic s_w_last, s_w_valid, s_w_ready, s_b_valid, s_b_ready;
    logic m_ar_valid, m_ar_ready, m_r_valid, m_r_ready, m_aw_valid, m_aw_ready;
    logic m_w_valid, m_w_ready, m_b_valid, m_b_ready;

    // Expected Lite beats in issue order, reads and writes kept apart
    logic [31:0] rd_addr [MAX_BEATS];
    prot_t rd_prot [MAX_BEATS];
    logic [`AXI_ID_WIDTH-1:0] rd_id [MAX_BEATS];
    logic rd_last [MAX_BEATS];
    resp_t rd_resp [MAX_BEATS];
    logic [31:0] wr_addr [MAX_BEATS];
    prot_t wr_prot [MAX_BEATS];
    resp_t wr_resp [MAX_BEATS];
    logic [31:0] wr_data [MAX_BEATS];
    logic [3:0] wr_strb [MAX_BEATS];
    logic wr_last [MAX_BEATS];
    logic [`AXI_ID_WIDTH-1:0] b_id_exp [MAX_BEATS];
    resp_t b_resp_exp [MAX_BEATS];
    int ar_rows [NUM_ROWS];
    int aw_rows [NUM_ROWS];
    logic [31:0] got_addr [MAX_BEATS];
    int n_rd = 0, n_wr = 0, n_ar = 0, n_b = 0;
    int ar_i = 0, aw_i = 0, w_i = 0, rd_acc = 0, rd_sent = 0, aw_acc = 0, w_acc = 0, b_sent = 0;
    int r_chk = 0, b_chk = 0, cycles = 0;

    axi_to_lite u_axi_to_lite (
        .clk        (clk),        .rstn       (rstn),
        .s_ar_id    (s_ar_id),    .s_ar_addr  (s_ar_addr),  .s_ar_len   (s_ar_len),
        .s_ar_size  (s_ar_size),  .s_ar_burst (s_ar_burst), .s_ar_prot  (s_ar_prot),
        .s_ar_valid (s_ar_valid), .s_ar_ready (s_ar_ready), .s_r_id     (s_r_id),
        .s_r_data   (s_r_data),   .s_r_resp   (s_r_resp),   .s_r_last   (s_r_last),
        .s_r_valid  (s_r_valid),  .s_r_ready  (s_r_ready),  .s_aw_id    (s_aw_id),
        .s_aw_addr  (s_aw_addr),  .s_aw_len   (s_aw_len),   .s_aw_size  (s_aw_size),
        .s_aw_burst (s_aw_burst), .s_aw_prot  (s_aw_prot),  .s_aw_valid (s_aw_valid),
        .s_aw_ready (s_aw_ready), .s_w_data   (s_w_data),   .s_w_strb   (s_w_strb),
        .s_w_last   (s_w_last),   .s_w_valid  (s_w_valid),  .s_w_ready  (s_w_ready),
        .s_b_id     (s_b_id),     .s_b_resp   (s_b_resp),   .s_b_valid  (s_b_valid),
        .s_b_ready  (s_b_ready),  .m_ar_addr  (m_ar_addr),  .m_ar_prot  (m_ar_prot),
        .m_ar_valid (m_ar_valid), .m_ar_ready (m_ar_ready), .m_r_data   (m_r_data),
        .m_r_resp   (m_r_resp),   .m_r_valid  (m_r_valid),  .m_r_ready  (m_r_ready),
        .m_aw_addr  (m_aw_addr),  .m_aw_prot  (m_aw_prot),  .m_aw_valid (m_aw_valid),
        .m_aw_ready (m_aw_ready), .m_w_data   (m_w_data),   .m_w_strb   (m_w_strb),
        .m_w_valid  (m_w_valid),  .m_w_ready  (m_w_ready),  .m_b_resp   (m_b_resp),
        .m_b_valid  (m_b_valid),  .m_b_ready  (m_b_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, what, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "stopped at the first wrong value");
        end
    endtask

    // Beat k of a burst by the AXI address rules, written in the form of the AXI spec
    function automatic logic [31:0] beat_addr(input row_t r, input int k);
        logic [31:0] bytes;
        logic [31:0] wrap_bytes;
        logic [31:0] lower;
        logic [31:0] a;
        bytes      = 32'd1 << r.size;
        wrap_bytes = bytes * (r.len + 1);
        lower      = (r.addr / wrap_bytes) * wrap_bytes;
        case (r.burst)
            BURST_FIXED: a = r.addr;
            BURST_WRAP: begin
                a = r.addr + k * bytes;
                // Past the top of the wrap window the address folds back to its bottom
                if (a >= lower + wrap_bytes) a = a - wrap_bytes;
            end
            // Only the first INCR beat may be unaligned
            default: a = (k == 0) ? r.addr : (r.addr / bytes) * bytes + k * bytes;
        endcase
        return a;
    endfunction

    task automatic load_table();
        rows[0] = '{1'b0, 4'h1, 32'h0000_1000, 3, 2, BURST_INCR, 3'd0, -1};
        rows[1] = '{1'b1, 4'h2, 32'h0000_2006, 4, 2, BURST_INCR, 3'd1, -1};
        rows[2] = '{1'b0, 4'h3, 32'h0000_3010, 2, 2, BURST_FIXED, 3'd2, 1};
        rows[3] = '{1'b1, 4'h4, 32'h0000_4038, 7, 2, BURST_WRAP, 3'd3, 2};
        rows[4] = '{1'b0, 4'h5, 32'h0000_5034, 3, 2, BURST_WRAP, 3'd4, -1};
        rows[5] = '{1'b1, 4'h6, 32'h0000_6ff0, 3, 2, BURST_INCR, 3'd5, 0};
        rows[6] = '{1'b0, 4'h7, 32'h0000_7003, 0, 0, BURST_INCR, 3'd6, 0};
        rows[7] = '{1'b1, 4'h8, 32'h0000_8100, 0, 2, BURST_FIXED, 3'd7, -1};
        rows[8] = '{1'b0, 4'h9, 32'h1234_5678, 15, 1, BURST_WRAP, 3'd7, -1};
        rows[9] = '{1'b1, 4'ha, 32'h0000_9002, 5, 1, BURST_INCR, 3'd2, 5};
    endtask

    // The slave answers SLVERR at the chosen beat and DECERR after it, so the merged write
    // response must be the first error, SLVERR
    task automatic build_expected();
        resp_t resp;
        for (int i = 0; i < NUM_ROWS; i++) begin
            for (int k = 0; k <= rows[i].len; k++) begin
                if (rows[i].err_idx < 0 || k < rows[i].err_idx) resp = RESP_OKAY;
                else if (k == rows[i].err_idx) resp = RESP_SLVERR;
                else resp = RESP_DECERR;
                if (rows[i].is_wr) begin
                    wr_addr[n_wr] = beat_addr(rows[i], k);
                    wr_prot[n_wr] = rows[i].prot;
                    wr_resp[n_wr] = resp;
                    wr_data[n_wr] = {8'hd0, 8'(i), 16'(k)};
                    wr_strb[n_wr] = 4'hf ^ k[3:0];
                    wr_last[n_wr] = k == rows[i].len;
                    n_wr++;
                end else begin
                    rd_addr[n_rd] = beat_addr(rows[i], k);
                    rd_prot[n_rd] = rows[i].prot;
                    rd_id[n_rd]   = rows[i].id;
                    rd_resp[n_rd] = resp;
                    rd_last[n_rd] = k == rows[i].len;
                    n_rd++;
                end
            end
            if (rows[i].is_wr) begin
                aw_rows[n_b]    = i;
                b_id_exp[n_b]   = rows[i].id;
                b_resp_exp[n_b] = (rows[i].err_idx < 0) ? RESP_OKAY : RESP_SLVERR;
                n_b++;
            end else begin
                ar_rows[n_ar] = i;
                n_ar++;
            end
        end
    endtask

    task automatic check_reset_outputs();
        check_value(m_ar_valid, 1'b0, "Lite ar valid around reset");
        check_value(m_aw_valid, 1'b0, "Lite aw valid around reset");
        check_value(s_b_valid, 1'b0, "AXI b valid around reset");
    endtask

    // Master side keeps every channel busy so bursts go back to back
    always @(posedge clk) begin : master_drive
        row_t ar_row;
        row_t aw_row;
        if (rstn) begin
            if (s_ar_valid && s_ar_ready) ar_i = ar_i + 1;
            if (s_aw_valid && s_aw_ready) aw_i = aw_i + 1;
            if (s_w_valid && s_w_ready) w_i = w_i + 1;
            s_ar_valid <= ar_i < n_ar;
            s_aw_valid <= aw_i < n_b;
            s_w_valid  <= w_i < n_wr;
            if (ar_i < n_ar) begin
                ar_row = rows[ar_rows[ar_i]];
                s_ar_id    <= ar_row.id;
                s_ar_addr  <= ar_row.addr;
                s_ar_len   <= 8'(ar_row.len);
                s_ar_size  <= 3'(ar_row.size);
                s_ar_burst <= ar_row.burst;
                s_ar_prot  <= ar_row.prot;
            end
            if (aw_i < n_b) begin
                aw_row = rows[aw_rows[aw_i]];
                s_aw_id    <= aw_row.id;
                s_aw_addr  <= aw_row.addr;
                s_aw_len   <= 8'(aw_row.len);
                s_aw_size  <= 3'(aw_row.size);
                s_aw_burst <= aw_row.burst;
                s_aw_prot  <= aw_row.prot;
            end
            s_w_data <= wr_data[w_i];
            s_w_strb <= wr_strb[w_i];
            s_w_last <= wr_last[w_i];
        end
    end

    // Lite read slave, the data of each beat is the address it was asked for
    always @(posedge clk) begin
        if (rstn) begin
            if (m_ar_valid && m_ar_ready) begin
                check_value(m_ar_addr, rd_addr[rd_acc], "Lite ar addr");
                check_value(m_ar_prot, rd_prot[rd_acc], "Lite ar prot");
                got_addr[rd_acc] = m_ar_addr;
                rd_acc = rd_acc + 1;
            end
            if (m_r_valid && m_r_ready) rd_sent = rd_sent + 1;
            m_r_valid <= rd_sent < rd_acc;
            m_r_data  <= got_addr[rd_sent];
            m_r_resp  <= rd_resp[rd_sent];
        end
    end

    // Lite write slave, a response goes out once both address and data of a beat arrived
    always @(posedge clk) begin
        if (rstn) begin
            if (m_aw_valid && m_aw_ready) begin
                check_value(m_aw_addr, wr_addr[aw_acc], "Lite aw addr");
                check_value(m_aw_prot, wr_prot[aw_acc], "Lite aw prot");
                aw_acc = aw_acc + 1;
            end
            if (m_w_valid && m_w_ready) begin
                check_value(m_w_data, wr_data[w_acc], "Lite w data");
                check_value(m_w_strb, wr_strb[w_acc], "Lite w strb");
                w_acc = w_acc + 1;
            end
            if (m_b_valid && m_b_ready) b_sent = b_sent + 1;
            m_b_valid <= (b_sent < aw_acc) && (b_sent < w_acc);
            m_b_resp  <= wr_resp[b_sent];
        end
    end

    // Beats beyond the table compare against unknown entries and fail there
    always @(posedge clk) begin
        if (rstn && s_r_valid && s_r_ready) begin
            check_value(s_r_id, rd_id[r_chk], "AXI r id");
            check_value(s_r_data, rd_addr[r_chk], "AXI r data");
            check_value(s_r_resp, rd_resp[r_chk], "AXI r resp");
            check_value(s_r_last, rd_last[r_chk], "AXI r last");
            r_chk <= r_chk + 1;
        end
        if (rstn && s_b_valid && s_b_ready) begin
            check_value(s_b_id, b_id_exp[b_chk], "AXI b id");
            check_value(s_b_resp, b_resp_exp[b_chk], "AXI b resp");
            b_chk <= b_chk + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, not all responses came back", cycles);
            $display("TESTBENCH FAILED");
            $fatal(1, "simulation ran too long");
        end
    end

    initial begin
        void'($urandom(23261));
        load_table();
        build_expected();
        rstn       <= 1'b0;
        s_ar_valid <= 1'b0;
        s_aw_valid <= 1'b0;
        s_w_valid  <= 1'b0;
        {s_ar_id, s_ar_addr, s_ar_len, s_ar_size, s_ar_prot} <= '0;
        {s_aw_id, s_aw_addr, s_aw_len, s_aw_size, s_aw_prot} <= '0;
        s_ar_burst <= BURST_INCR;
        s_aw_burst <= BURST_INCR;
        {s_w_data, s_w_strb, s_w_last, s_r_ready, s_b_ready} <= '0;
        {m_ar_ready, m_aw_ready, m_w_ready, m_r_valid, m_b_valid, m_r_data} <= '0;
        m_r_resp <= RESP_OKAY;
        m_b_resp <= RESP_OKAY;
        repeat (10) begin
            @(posedge clk);
            check_reset_outputs();
        end
        rstn <= 1'b1;
        @(posedge clk);
        check_reset_outputs();
        // Random back-pressure on both sides until every burst has been answered
        while (r_chk < n_rd || b_chk < n_b) begin
            m_ar_ready <= ($urandom % 4) != 0;
            m_aw_ready <= ($urandom % 4) != 0;
            m_w_ready  <= ($urandom % 4) != 0;
            s_r_ready  <= ($urandom % 3) != 0;
            s_b_ready  <= ($urandom % 3) != 0;
            @(posedge clk);
        end
        {m_ar_ready, m_aw_ready, m_w_ready, s_r_ready, s_b_ready} <= '1;
        // Quiet period so a late or duplicated beat still shows up
        repeat (20) @(posedge clk);
        if (rd_acc == n_rd && aw_acc == n_wr && w_acc == n_wr && r_chk == n_rd && b_chk == n_b) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("Beat counts differ from the stimulus table at the end of the run");
            $display("TESTBENCH FAILED");
            $fatal(1, "beat count check failed");
        end
    end

endmodule
